// File: project.f
+incdir+test
source/raster_types_pkg.sv
source/pipe_ctrl_pkg.sv
source/stage_control.sv
source/work_timer.sv
source/raster_data.sv
source/pixel_stage_data.sv
source/ray_core_top.sv
test/ray_core_tb.sv

// File: Bender.yml
package:
  name: ray_core

sources:
  - source/raster_types_pkg.sv
  - source/pipe_ctrl_pkg.sv
  - source/stage_control.sv
  - source/work_timer.sv
  - source/raster_data.sv
  - source/pixel_stage_data.sv
  - source/ray_core_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/ray_core_tb.sv

// File: test/ray_core_checks.svh
// compare tasks for the ray core testbench
// one task per result type, counts checks and errors as they go
`ifndef RAY_CORE_CHECKS_SVH
`define RAY_CORE_CHECKS_SVH

function automatic string format_pixel(input pixel_t p);
    return $sformatf("x=%03h y=%03h rgb=%02h_%02h_%02h",
                     p.x, p.y, p.channel[2], p.channel[1], p.channel[0]);
endfunction

task automatic check_pixel(input string name, input pixel_t expected,
                           input pixel_t actual, inout int fails);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        fails++;
        $display("MISMATCH %s: expected %s actual %s", name,
                 format_pixel(expected), format_pixel(actual));
    end
endtask

task automatic check_flag(input string name, input logic expected,
                          input logic actual, inout int fails);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        fails++;
        $display("MISMATCH %s: expected %b actual %b", name, expected, actual);
    end
endtask

`endif

// File: test/ray_core_tb.sv
// ray core pipeline testbench
// random requests under random back-pressure, checked against a model queue
`timescale 1ns/1ps

module ray_core_tb;
    import raster_types_pkg::*;

    localparam int NUM_REQUESTS = 200;
    localparam int RESET_CYCLES = 5;
    localparam int CYCLES_PER_REQUEST = 40;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_REQUESTS * CYCLES_PER_REQUEST;
    localparam int QUIET_CYCLES = 60;

    logic clk = 1'b0;
    logic resetn;
    logic req_add;
    ray_request_t req_data;
    logic req_full;
    logic pix_hold;
    logic pix_valid;
    pixel_t pix_data;

    integer seed = 32'hf71f_7a88;
    int check_count = 0;
    int error_count = 0;
    int cycle_count = 0;
    int accepted = 0;
    int pixels_out = 0;
    int gap = 0;
    int reset_fails = 0;
    int order_fails = 0;
    int hold_fails = 0;
    int flow_fails = 0;
    int drain_fails = 0;
    logic monitor_on = 1'b0;
    logic rise_due = 1'b0;
    logic hold_prev = 1'b0;
    logic pending = 1'b0;
    pixel_t snapshot = '0;
    pixel_t expected;
    pixel_t model_q[$];

    `include "ray_core_checks.svh"

    ray_core_top DUT (
        .clk       (clk),
        .resetn    (resetn),
        .req_add   (req_add),
        .req_data  (req_data),
        .req_full  (req_full),
        .pix_hold  (pix_hold),
        .pix_valid (pix_valid),
        .pix_data  (pix_data)
    );

    always #4 clk = ~clk;

    // reference colour rule, upper byte of each component
    function automatic pixel_t expected_pixel(input ray_request_t req);
        pixel_t p;
        p.x = req.x;
        p.y = req.y;
        for (int d = 0; d < NUM_DIMS; d++) begin
            p.channel[d] = channel_t'(req.dir[d] >> (DIR_WIDTH - CHANNEL_WIDTH));
        end
        return p;
    endfunction

    task automatic random_request(output ray_request_t req);
        req.x = coord_t'($random(seed));
        req.y = coord_t'($random(seed));
        for (int d = 0; d < NUM_DIMS; d++) begin
            req.dir[d] = dir_comp_t'($random(seed));
        end
    endtask

    task automatic report_test(input string name, input int fails);
        $display("test %-13s %s (%0d errors)", name, (fails == 0) ? "passed" : "FAILED", fails);
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, %0d of %0d pixels out", cycle_count,
                     pixels_out, accepted);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // output monitor, samples mid-cycle
    // ------------------------------------------------------------
    always @(negedge clk) begin
        if (monitor_on) begin
            // the DUT saw hold at the last edge, so no release now
            if (hold_prev) begin
                check_flag("back_pressure", 1'b0, pix_valid, hold_fails);
            end
            // a loaded pixel stays put until it is released
            if (pending) begin
                check_pixel("hold_stable", snapshot, pix_data, hold_fails);
            end else if (pix_data !== snapshot) begin
                pending = 1'b1;
            end
            snapshot = pix_data;
            if (pix_valid) begin
                pending = 1'b0;
                pixels_out++;
                if (model_q.size() == 0) begin
                    error_count++;
                    order_fails++;
                    $display("pixel out with no request outstanding");
                end else begin
                    expected = model_q.pop_front();
                    check_pixel("colour_order", expected, pix_data, order_fails);
                end
            end
            hold_prev = pix_hold;
        end
    end

    initial begin
        resetn = 1'b0;
        req_add = 1'b0;
        req_data = '0;
        pix_hold = 1'b0;

        // ------------------------------------------------------------
        // reset
        // ------------------------------------------------------------
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_flag("reset", 1'b0, pix_valid, reset_fails);
            check_flag("reset", 1'b0, req_full, reset_fails);
        end
        @(posedge clk);
        #1 resetn = 1'b1;
        @(negedge clk);
        check_flag("reset", 1'b0, pix_valid, reset_fails);
        check_flag("reset", 1'b0, req_full, reset_fails);
        report_test("reset", reset_fails);
        monitor_on = 1'b1;

        // ------------------------------------------------------------
        // random stream with back-pressure
        // ------------------------------------------------------------
        gap = {$random(seed)} % 4;
        while (accepted < NUM_REQUESTS) begin
            @(posedge clk);
            #1;
            req_add = 1'b0;
            pix_hold = ({$random(seed)} % 100) < 30;
            if (rise_due) begin
                check_flag("flow_control", 1'b1, req_full, flow_fails);
                rise_due = 1'b0;
            end
            if (gap > 0) begin
                gap--;
            end else if (!req_full) begin
                random_request(req_data);
                req_add = 1'b1;
                model_q.push_back(expected_pixel(req_data));
                accepted++;
                rise_due = 1'b1;
                gap = {$random(seed)} % 4;
            end
        end
        @(posedge clk);
        #1;
        req_add = 1'b0;
        pix_hold = 1'b0;
        check_flag("flow_control", 1'b1, req_full, flow_fails);

        // drain, the cycle counter catches a stuck pipeline
        while (pixels_out < accepted) begin
            @(posedge clk);
        end
        repeat (QUIET_CYCLES) @(posedge clk);
        if (pixels_out != accepted || model_q.size() != 0) begin
            error_count++;
            drain_fails++;
            $display("pixel count wrong: %0d out for %0d accepted, %0d left in model",
                     pixels_out, accepted, model_q.size());
        end
        check_flag("drain", 1'b0, req_full, drain_fails);
        report_test("colour_order", order_fails);
        report_test("back_pressure", hold_fails);
        report_test("flow_control", flow_fails);
        report_test("drain", drain_fails);

        $display("checks %0d, errors %0d, pixels %0d of %0d requests",
                 check_count, error_count, pixels_out, accepted);
        if (error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: source/ray_core_top.sv
// ray core pixel pipeline
// raster, shadowing and shading stages chained by valid/full handshakes
`timescale 1ns/1ps

module ray_core_top (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          req_add,
    input  raster_types_pkg::ray_request_t req_data,
    output logic                          req_full,
    input  logic                          pix_hold,
    output logic                          pix_valid,
    output raster_types_pkg::pixel_t       pix_data
);
    import raster_types_pkg::*;

    logic ras_valid;
    logic ras_slot_load;
    logic ras_cur_load;
    logic ras_out_load;
    logic ras_working;
    logic ras_work_done;
    pixel_t ras_pix;

    logic shdw_full;
    logic shdw_valid;
    logic shdw_slot_load;
    logic shdw_cur_load;
    logic shdw_out_load;
    pixel_t shdw_pix;

    logic shdr_full;
    logic shdr_slot_load;
    logic shdr_cur_load;
    logic shdr_out_load;

    // ------------------------------------------------------------
    // raster
    // ------------------------------------------------------------
    stage_control #(.has_work_phase(1'b1)) u_ras_ctrl (
        .clk       (clk),
        .resetn    (resetn),
        .add       (req_add),
        .hold      (shdw_full),
        .work_done (ras_work_done),
        .full      (req_full),
        .valid     (ras_valid),
        .slot_load (ras_slot_load),
        .cur_load  (ras_cur_load),
        .out_load  (ras_out_load),
        .working   (ras_working)
    );

    work_timer u_ras_timer (
        .clk    (clk),
        .resetn (resetn),
        .run    (ras_working),
        .done   (ras_work_done)
    );

    raster_data u_ras_data (
        .clk       (clk),
        .resetn    (resetn),
        .slot_load (ras_slot_load),
        .cur_load  (ras_cur_load),
        .out_load  (ras_out_load),
        .req_in    (req_data),
        .pix_out   (ras_pix)
    );

    // ------------------------------------------------------------
    // shadowing
    // ------------------------------------------------------------
    stage_control #(.has_work_phase(1'b0)) u_shdw_ctrl (
        .clk       (clk),
        .resetn    (resetn),
        .add       (ras_valid),
        .hold      (shdr_full),
        .work_done (1'b0),
        .full      (shdw_full),
        .valid     (shdw_valid),
        .slot_load (shdw_slot_load),
        .cur_load  (shdw_cur_load),
        .out_load  (shdw_out_load),
        .working   ()
    );

    pixel_stage_data u_shdw_data (
        .clk       (clk),
        .resetn    (resetn),
        .slot_load (shdw_slot_load),
        .cur_load  (shdw_cur_load),
        .out_load  (shdw_out_load),
        .pix_in    (ras_pix),
        .pix_out   (shdw_pix)
    );

    // ------------------------------------------------------------
    // shading
    // ------------------------------------------------------------
    stage_control #(.has_work_phase(1'b0)) u_shdr_ctrl (
        .clk       (clk),
        .resetn    (resetn),
        .add       (shdw_valid),
        .hold      (pix_hold),
        .work_done (1'b0),
        .full      (shdr_full),
        .valid     (pix_valid),
        .slot_load (shdr_slot_load),
        .cur_load  (shdr_cur_load),
        .out_load  (shdr_out_load),
        .working   ()
    );

    pixel_stage_data u_shdr_data (
        .clk       (clk),
        .resetn    (resetn),
        .slot_load (shdr_slot_load),
        .cur_load  (shdr_cur_load),
        .out_load  (shdr_out_load),
        .pix_in    (shdw_pix),
        .pix_out   (pix_data)
    );

endmodule

// File: source/pixel_stage_data.sv
// forwarding stage datapath
// slot, current and output pixel registers for shadowing and shading
`timescale 1ns/1ps

module pixel_stage_data (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     slot_load,
    input  logic                     cur_load,
    input  logic                     out_load,
    input  raster_types_pkg::pixel_t pix_in,
    output raster_types_pkg::pixel_t pix_out
);
    import raster_types_pkg::*;

    pixel_t slot_q;
    pixel_t cur_q;
    pixel_t out_src;

    always_ff @(posedge clk) begin
        if (slot_load) begin
            slot_q <= pix_in;
        end
        if (cur_load) begin
            cur_q <= slot_q;
        end
    end

    // without a work phase current and output load on the same edge,
    // so the slot bypasses the current register then
    assign out_src = cur_load ? slot_q : cur_q;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            pix_out <= '0;
        end else if (out_load) begin
            pix_out <= out_src;
        end
    end

endmodule

// File: source/raster_data.sv
// raster stage datapath
// request slot, current request and the colour-forming output register
`timescale 1ns/1ps

module raster_data (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          slot_load,
    input  logic                          cur_load,
    input  logic                          out_load,
    input  raster_types_pkg::ray_request_t req_in,
    output raster_types_pkg::pixel_t       pix_out
);
    import raster_types_pkg::*;

    ray_request_t slot_q;
    ray_request_t cur_q;
    pixel_t pix_d;

    // payload only, no reset
    always_ff @(posedge clk) begin
        if (slot_load) begin
            slot_q <= req_in;
        end
        if (cur_load) begin
            cur_q <= slot_q;
        end
    end

    // ------------------------------------------------------------
    // colour rule
    // ------------------------------------------------------------
    always_comb begin
        pix_d.x = cur_q.x;
        pix_d.y = cur_q.y;
        // upper byte of each direction component
        for (int i = 0; i < NUM_DIMS; i++) begin
            pix_d.channel[i] = cur_q.dir[i][DIR_WIDTH-1 -: CHANNEL_WIDTH];
        end
    end

    // cleared so the stage output is defined before the first pixel
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            pix_out <= '0;
        end else if (out_load) begin
            pix_out <= pix_d;
        end
    end

endmodule

// File: source/work_timer.sv
// raster work timer
// free counter that flags each wrap to zero, one work period of 16 cycles
`timescale 1ns/1ps

module work_timer (
    input  logic clk,
    input  logic resetn,
    input  logic run,
    output logic done
);
    import pipe_ctrl_pkg::*;

    work_count_t count;

    // count sits at zero between work periods, so each run starts clean
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            count <= '0;
        end else if (run) begin
            count <= count + work_count_t'(1);
        end
    end

    // high on the cycle the count wraps back to zero
    assign done = run && (count == TIMER_LAST);

endmodule

// File: source/stage_control.sv
// pipeline stage control
// one-entry slot flag and idle/work/done FSM, drives the data strobes
`timescale 1ns/1ps

module stage_control #(
    parameter bit has_work_phase = 1'b1
) (
    input  logic clk,
    input  logic resetn,
    input  logic add,
    input  logic hold,
    input  logic work_done,
    output logic full,
    output logic valid,
    output logic slot_load,
    output logic cur_load,
    output logic out_load,
    output logic working
);
    import pipe_ctrl_pkg::*;

    stage_state_e state;
    stage_state_e state_next;
    logic slot_take;
    logic slot_release;

    // add is only legal while the slot is empty
    assign slot_take = add && !full;

    // slot moves to the current register as soon as the FSM is idle
    assign slot_release = (state == ST_IDLE) && full;

    // ------------------------------------------------------------
    // next state
    // ------------------------------------------------------------
    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (full) begin
                    state_next = has_work_phase ? ST_WORK : ST_DONE;
                end
            end
            ST_WORK: begin
                if (work_done) begin
                    state_next = ST_DONE;
                end
            end
            ST_DONE: begin
                if (!hold) begin
                    state_next = ST_IDLE;
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    // ------------------------------------------------------------
    // strobes
    // ------------------------------------------------------------
    assign slot_load = slot_take;
    assign cur_load = slot_release;
    // output register written on the edge that enters done
    assign out_load = (state != ST_DONE) && (state_next == ST_DONE);
    assign working = (state == ST_WORK);

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state <= ST_IDLE;
            full <= 1'b0;
            valid <= 1'b0;
        end else begin
            state <= state_next;
            // one cycle pulse when leaving done
            valid <= (state == ST_DONE) && !hold;
            if (slot_take) begin
                full <= 1'b1;
            end else if (slot_release) begin
                full <= 1'b0;
            end
        end
    end

endmodule

// File: source/pipe_ctrl_pkg.sv
// pipeline control definitions
// stage state encoding and work timer constants
package pipe_ctrl_pkg;

    // ------------------------------------------------------------
    // work timer
    // ------------------------------------------------------------

    // 4 bits give a 16 cycle period from one wrap to the next
    localparam int TIMER_WIDTH = 4;

    typedef logic [TIMER_WIDTH-1:0] work_count_t;

    // last count before the wrap back to zero
    localparam work_count_t TIMER_LAST = '1;

    // ------------------------------------------------------------
    // stage state machine
    // ------------------------------------------------------------

    // idle  waits for an occupied slot
    // work  raster only, runs the work timer
    // done  output register written, waits for downstream room
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_WORK = 2'd1,
        ST_DONE = 2'd2
    } stage_state_e;

endpackage

// File: source/raster_types_pkg.sv
// raster pixel formats
// screen coordinates, ray direction components, colour channels and the
// request and pixel structs passed between the stages
package raster_types_pkg;

    // ------------------------------------------------------------
    // widths
    // ------------------------------------------------------------
    localparam int COORD_WIDTH = 10;
    localparam int DIR_WIDTH = 16;
    localparam int CHANNEL_WIDTH = 8;
    // dimensions of a direction, also colour channels per pixel
    localparam int NUM_DIMS = 3;

    typedef logic [COORD_WIDTH-1:0] coord_t;
    typedef logic [DIR_WIDTH-1:0] dir_comp_t;
    typedef logic [CHANNEL_WIDTH-1:0] channel_t;

    // ------------------------------------------------------------
    // payloads
    // ------------------------------------------------------------

    // pixel request from outside, 68 bits
    typedef struct packed {
        coord_t x;
        coord_t y;
        dir_comp_t [NUM_DIMS-1:0] dir;
    } ray_request_t;

    // coloured pixel, 44 bits
    typedef struct packed {
        coord_t x;
        coord_t y;
        channel_t [NUM_DIMS-1:0] channel;
    } pixel_t;

endpackage
